// File: verilog/surf_link_pkg.sv
`default_nettype none

package surf_link_pkg;

    // number of SURF digitizers hanging off the trigger board
    localparam int NUM_SURF = 7;

    // each SURF reports its state on a 4-bit COUT and an 8-bit DOUT
    localparam int COUT_W = 4;
    localparam int DOUT_W = 8;

    // consecutive all-ones COUT cycles that mean the SURF has gone away
    // must be a power of two since the counter uses its top bit as the kill flag
    localparam int LOSS_COUNT = 16;

    // one extra bit above the count range holds the kill flag
    localparam int LOSS_CNT_W = $clog2(LOSS_COUNT) + 1;

    // one SURF's slice of the COUT bus
    typedef logic [COUT_W-1:0] cout_t;

    // one SURF's slice of the DOUT bus
    typedef logic [DOUT_W-1:0] dout_t;

endpackage

`default_nettype wire

// File: verilog/surf_status_pkg.sv
`default_nettype none

package surf_status_pkg;

    import surf_link_pkg::*;

    // per-SURF flags as produced by one lane tracker
    // field order matters, the top level packs these bit by bit
    typedef struct packed {
        logic train_in_req;
        logic train_out_rdy;
        logic live;
    } surf_flags_t;

    // one bit per SURF, bit index equals SURF index
    typedef logic [NUM_SURF-1:0] surf_vec_t;

    // everything that crosses into the register clock as a single payload
    typedef struct packed {
        surf_vec_t trainin_req;
        surf_vec_t trainout_rdy;
        surf_vec_t live;
    } surf_status_t;

endpackage

`default_nettype wire

// File: verilog/surf_status_if.sv
`timescale 1ns/100ps
`default_nettype none

// status bundle between the lane tracker array and the clock crossing logic
// all signals are plain levels in the sys_clk_i domain
interface surf_status_if
    import surf_status_pkg::*;
();

    // flag vectors, each lane drives only its own bit
    surf_vec_t trainin_req;
    surf_vec_t trainout_rdy;
    surf_vec_t live;

    // train-complete already synchronized into sys_clk_i
    surf_vec_t complete_sys;

    // lane side produces the flags and consumes the synchronized complete
    modport lanes (
        output trainin_req,
        output trainout_rdy,
        output live,
        input  complete_sys
    );

    // crossing side reads the flags and supplies the synchronized complete
    modport crossing (
        input  trainin_req,
        input  trainout_rdy,
        input  live,
        output complete_sys
    );

endinterface

`default_nettype wire

// File: verilog/surf_lane_tracker.sv
`timescale 1ns/100ps
`default_nettype none

// tracks one SURF from boot through training to live, entirely in sys_clk_i
// a SURF that drops its RX clock parks COUT at all ones, that is what the loss counter watches
// DOUT is deliberately not used for loss detection since it can carry almost any pattern
module surf_lane_tracker
    import surf_link_pkg::*;
    import surf_status_pkg::*;
(
    input  wire logic        sys_clk_i,
    input  wire logic        sys_clk_ok_i,
    input  wire cout_t       cout_i,
    input  wire dout_t       dout_i,
    input  wire logic        complete_i,
    output surf_flags_t      flags_o
);

    logic                  boot_seen;
    logic [LOSS_CNT_W-1:0] loss_cnt;
    logic                  kill;
    logic                  cout_ones;
    logic                  dout_zero;
    logic                  train_in_req;
    logic                  train_out_rdy;
    logic                  live;

    // COUT leaving all ones is what "COUT goes low" really means here
    assign cout_ones = (cout_i == '1);
    assign dout_zero = (dout_i == '0);

    // the counter saturates into its top bit exactly when the run length is reached
    assign kill = loss_cnt[LOSS_CNT_W-1];

    // loss counter only runs while the SURF is live or before any boot was seen
    // a trained-but-not-live SURF is allowed to idle with COUT high
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            loss_cnt <= '0;
        end else if ((live || !boot_seen) && cout_ones) begin
            loss_cnt <= {1'b0, loss_cnt[LOSS_CNT_W-2:0]} + LOSS_CNT_W'(1);
        end else begin
            loss_cnt <= '0;
        end
    end

    // boot-seen is a once-and-done, the first loss marks that the SURF has come up
    // a later loss of a live SURF sets it again which changes nothing
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            boot_seen <= 1'b0;
        end else if (kill) begin
            boot_seen <= 1'b1;
        end
    end

    // DOUT dropping to zero after boot means the SURF has clocks and wants CIN training
    // the kill always wins over every set below
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            train_in_req <= 1'b0;
        end else if (kill) begin
            train_in_req <= 1'b0;
        end else if (dout_zero && boot_seen) begin
            train_in_req <= 1'b1;
        end
    end

    // COUT leaving all ones during a request means the SURF outputs are in training
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            train_out_rdy <= 1'b0;
        end else if (kill) begin
            train_out_rdy <= 1'b0;
        end else if (train_in_req && !cout_ones) begin
            train_out_rdy <= 1'b1;
        end
    end

    // live once the outbound link is trained and the startup logic says it is done
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            live <= 1'b0;
        end else if (kill) begin
            live <= 1'b0;
        end else if (train_out_rdy && complete_i) begin
            live <= 1'b1;
        end
    end

    assign flags_o.train_in_req  = train_in_req;
    assign flags_o.train_out_rdy = train_out_rdy;
    assign flags_o.live          = live;

    // flags only ever build up in order, so each one implies the one before it
    a_rdy_needs_req: assert property (
        @(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
        train_out_rdy |-> train_in_req
    ) else $error("train-out ready without train-in request");

    a_live_needs_rdy: assert property (
        @(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
        live |-> train_out_rdy
    ) else $error("live without train-out ready");

    // a loss must wipe the whole lane on the next edge, whatever else is pending
    a_kill_clears: assert property (
        @(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
        kill |=> !(train_in_req || train_out_rdy || live)
    ) else $error("flags survived a kill");

endmodule

`default_nettype wire

// File: verilog/status_sync.sv
`timescale 1ns/100ps
`default_nettype none

// two-flop level synchronizer into dst_clk_i
// every payload bit is an independent quasi-static level, so no bus coherency is implied
// the output follows the input after two destination edges, two to three cycles in all
module status_sync #(
    parameter type payload_t = logic
) (
    input  wire logic     dst_clk_i,
    input  wire logic     sys_clk_ok_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    // first stage may go metastable, second stage is the one that gets used
    // both stages should be placed close together with the vendor crossing
    // attributes applied in the implementation constraints
    payload_t sync_meta;
    payload_t sync_q;

    always_ff @(posedge dst_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= d_i;
            sync_q    <= sync_meta;
        end
    end

    assign q_o = sync_q;

endmodule

`default_nettype wire

// File: verilog/surf_live_detector.sv
`timescale 1ns/100ps
`default_nettype none

// SURF liveness tracker for the seven SURFs on the trigger board
// COUT and DOUT arrive in sys_clk_i, the resulting flags are consumed in wb_clk_i
// DOUT low after boot is a train-in request, COUT off all ones then means train-out ready
// live additionally waits for train_complete_i from the startup sequencer
module surf_live_detector
    import surf_link_pkg::*;
    import surf_status_pkg::*;
(
    input  wire logic                       sys_clk_i,
    input  wire logic                       sys_clk_ok_i,
    input  wire logic                       wb_clk_i,
    // seven 4-bit COUT groups, SURF 0 in the low bits
    input  wire logic [NUM_SURF*COUT_W-1:0] cout_i,
    // seven 8-bit DOUT groups, SURF 0 in the low bits
    input  wire logic [NUM_SURF*DOUT_W-1:0] dout_i,
    // asynchronous to sys_clk_i, one bit per SURF
    input  wire logic [NUM_SURF-1:0]        train_complete_i,
    output logic      [NUM_SURF-1:0]        trainin_req_o,
    output logic      [NUM_SURF-1:0]        trainout_rdy_o,
    output logic      [NUM_SURF-1:0]        surf_live_o
);

    surf_status_if status_if ();

    surf_status_t status_sys;
    surf_status_t status_wb;

    // train-complete comes from register space, bring it into sys_clk_i first
    status_sync #(
        .payload_t (surf_vec_t)
    ) u_complete_sync (
        .dst_clk_i    (sys_clk_i),
        .sys_clk_ok_i (sys_clk_ok_i),
        .d_i          (train_complete_i),
        .q_o          (status_if.complete_sys)
    );

    // one tracker per SURF, each owns one bit of every flag vector
    for (genvar i = 0; i < NUM_SURF; i++) begin : g_lane
        surf_lane_tracker u_lane (
            .sys_clk_i    (sys_clk_i),
            .sys_clk_ok_i (sys_clk_ok_i),
            .cout_i       (cout_i[COUT_W*i +: COUT_W]),
            .dout_i       (dout_i[DOUT_W*i +: DOUT_W]),
            .complete_i   (status_if.complete_sys[i]),
            // same field order as surf_flags_t
            .flags_o      ({status_if.trainin_req[i],
                            status_if.trainout_rdy[i],
                            status_if.live[i]})
        );
    end

    assign status_sys = '{
        trainin_req:  status_if.trainin_req,
        trainout_rdy: status_if.trainout_rdy,
        live:         status_if.live
    };

    // all three flag vectors cross into the register clock together
    status_sync #(
        .payload_t (surf_status_t)
    ) u_status_sync (
        .dst_clk_i    (wb_clk_i),
        .sys_clk_ok_i (sys_clk_ok_i),
        .d_i          (status_sys),
        .q_o          (status_wb)
    );

    assign trainin_req_o  = status_wb.trainin_req;
    assign trainout_rdy_o = status_wb.trainout_rdy;
    assign surf_live_o    = status_wb.live;

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

// free-running clock for the testbench, first rising edge after half a period
module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_surf_live_detector.sv
`timescale 1ns/100ps
`default_nettype none

// testbench for the SURF liveness tracker
// each cases line drives one SURF for a number of cycles, lets the flags settle and compares
module tb_surf_live_detector
    import surf_link_pkg::*;
    import surf_status_pkg::*;
();

    localparam int SYS_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 16;
    // one sys cycle of flag update plus up to three wb cycles of crossing fits in here
    localparam int SETTLE_CYCLES = 8;
    localparam int MARGIN_CYCLES = 200;

    // one parsed cases line, its name is kept in a queue of its own
    typedef struct packed {
        logic [2:0]   surf;
        cout_t        cout;
        dout_t        dout;
        logic [7:0]   hold;
        cout_t        rest;
        surf_vec_t    complete;
        surf_status_t exp_status;
    } step_t;

    logic                       sys_clk;
    logic                       wb_clk;
    logic                       sys_clk_ok;
    logic [NUM_SURF*COUT_W-1:0] cout;
    logic [NUM_SURF*DOUT_W-1:0] dout;
    surf_vec_t                  train_complete;
    surf_vec_t                  trainin_req;
    surf_vec_t                  trainout_rdy;
    surf_vec_t                  surf_live;

    step_t  steps[$];
    string  names[$];
    // COUT each SURF keeps showing between steps
    cout_t  cout_reg [NUM_SURF];
    integer seed = 32'h55c4;
    longint watchdog_ns = 0;

    tb_clock_gen #(.PERIOD_NS(8.0))  u_sys_clk (.clk_o(sys_clk));
    tb_clock_gen #(.PERIOD_NS(12.0)) u_wb_clk  (.clk_o(wb_clk));

    surf_live_detector dut (
        .sys_clk_i        (sys_clk),
        .sys_clk_ok_i     (sys_clk_ok),
        .wb_clk_i         (wb_clk),
        .cout_i           (cout),
        .dout_i           (dout),
        .train_complete_i (train_complete),
        .trainin_req_o    (trainin_req),
        .trainout_rdy_o   (trainout_rdy),
        .surf_live_o      (surf_live)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    // idle SURFs show a fresh nonzero DOUT every cycle, which must never count as a request
    function automatic dout_t random_filler();
        dout_t v;
        v = dout_t'($random(seed));
        if (v == '0) begin
            v = dout_t'(1);
        end
        return v;
    endfunction

    // new values go out 1 ns after the rising sys edge, active < 0 means no SURF is held
    task automatic drive_cycle(input int active, input dout_t active_dout);
        int s;
        @(posedge sys_clk);
        #1;
        for (s = 0; s < NUM_SURF; s++) begin
            cout[COUT_W*s +: COUT_W] = cout_reg[s];
            dout[DOUT_W*s +: DOUT_W] = (s == active) ? active_dout : random_filler();
        end
    endtask

    task automatic check_vec(input string what, input surf_vec_t exp, input surf_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", what, exp, act));
        end
    endtask

    task automatic check_status(input string what, input surf_status_t exp,
                                input surf_status_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", what, exp, act));
        end
    endtask

    // each output on its own first, then the three together as one payload
    task automatic check_outputs(input string what, input surf_status_t exp);
        surf_status_t act;
        act.trainin_req  = trainin_req;
        act.trainout_rdy = trainout_rdy;
        act.live         = surf_live;
        check_vec({what, " trainin_req"}, exp.trainin_req, trainin_req);
        check_vec({what, " trainout_rdy"}, exp.trainout_rdy, trainout_rdy);
        check_vec({what, " surf_live"}, exp.live, surf_live);
        check_status(what, exp, act);
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        int          surf;
        int          hold;
        string       line;
        string       name;
        logic [31:0] f [7];
        step_t       st;
        longint      total;
        total = 0;
        fd = $fopen("sim/surf_live_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the cases file sim/surf_live_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // comment and blank lines hold no step
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %h %h %d %h %h %h %h %h", name, surf, f[0], f[1],
                        hold, f[2], f[3], f[4], f[5], f[6]);
            if (n != 10 || surf < 0 || surf >= NUM_SURF) begin
                abort_run($sformatf("could not read this cases line: %s", line));
            end
            st.surf                    = surf[2:0];
            st.cout                    = cout_t'(f[0]);
            st.dout                    = dout_t'(f[1]);
            st.hold                    = hold[7:0];
            st.rest                    = cout_t'(f[2]);
            st.complete                = surf_vec_t'(f[3]);
            st.exp_status.trainin_req  = surf_vec_t'(f[4]);
            st.exp_status.trainout_rdy = surf_vec_t'(f[5]);
            st.exp_status.live         = surf_vec_t'(f[6]);
            steps.push_back(st);
            names.push_back(name);
            total += hold + SETTLE_CYCLES;
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            abort_run("the cases file holds no steps");
        end
        watchdog_ns = (RESET_CYCLES + SETTLE_CYCLES + total + MARGIN_CYCLES) * SYS_PERIOD_NS;
    endtask

    // hold the step's COUT and DOUT, drop COUT to its rest value, settle, then compare
    task automatic run_step(input int idx);
        step_t st;
        st = steps[idx];
        cout_reg[st.surf] = st.cout;
        train_complete    = st.complete;
        repeat (st.hold) drive_cycle(st.surf, st.dout);
        cout_reg[st.surf] = st.rest;
        repeat (SETTLE_CYCLES) drive_cycle(-1, '0);
        check_outputs(names[idx], st.exp_status);
    endtask

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        abort_run("watchdog expired before all cases were run");
    end

    initial begin
        int idx;
        sys_clk_ok     = 1'b0;
        cout           = '0;
        dout           = '0;
        train_complete = '0;
        for (idx = 0; idx < NUM_SURF; idx++) begin
            cout_reg[idx] = '0;
        end
        load_cases();
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #1;
        sys_clk_ok = 1'b1;
        repeat (SETTLE_CYCLES) drive_cycle(-1, '0);
        check_outputs("after_reset", '0);
        for (idx = 0; idx < steps.size(); idx++) begin
            run_step(idx);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/surf_live_cases.txt
# name surf(dec) cout(hex) dout(hex) hold(dec) rest_cout(hex) complete(hex)
# then expected trainin_req trainout_rdy live (hex), checked eight cycles after the hold
idle_dout_zero   0 0 00  4 0 00 00 00 00
boot_s2          2 f 5a 16 f 00 00 00 00
req_s2           2 f 00  4 f 00 04 00 00
rdy_s2           2 3 3c  4 3 00 04 04 00
complete_other   2 3 3c  4 3 01 04 04 00
live_s2          2 3 3c  4 3 05 04 04 04
boot_s5          5 f a5 16 f 05 04 04 04
req_s5           5 f 00  4 f 05 24 04 04
rdy_s5           5 9 c3  4 9 05 24 24 04
live_s5          5 9 c3  4 9 25 24 24 24
short_run_s2     2 f 3c 15 6 25 24 24 24
loss_s2          2 f 3c 16 f 25 20 20 20
rereq_s2         2 f 00  4 f 25 24 20 20
boot_s6          6 f 81 16 f 25 24 20 20
filler_s6        6 f 7e  8 f 25 24 20 20
boot_s0          0 f 11 16 f 7f 24 20 20
boot_s4          4 f 22 16 f 7f 24 20 20
train_s0         0 f 00  4 3 7f 25 21 21
boot_s1          1 f 44 16 f 7f 25 21 21
train_s6         6 f 00  4 c 7f 65 61 61
boot_s3          3 f 88 16 f 7f 65 61 61
train_s4         4 f 00  4 a 7f 75 71 71
rdy_s2_again     2 5 3c  4 5 7f 75 75 75
train_s1         1 f 00  4 6 7f 77 77 77
train_s3         3 f 00  4 e 7f 7f 7f 7f

// File: filelist.f
verilog/surf_link_pkg.sv
verilog/surf_status_pkg.sv
verilog/surf_status_if.sv
verilog/surf_lane_tracker.sv
verilog/status_sync.sv
verilog/surf_live_detector.sv
sim/tb_clock_gen.sv
sim/tb_surf_live_detector.sv

// File: Bender.yml
package:
  name: surf_live_detector

sources:
  # synthesizable design, packages and interface first
  - target: any(rtl, simulation)
    files:
      - verilog/surf_link_pkg.sv
      - verilog/surf_status_pkg.sv
      - verilog/surf_status_if.sv
      - verilog/surf_lane_tracker.sv
      - verilog/status_sync.sv
      - verilog/surf_live_detector.sv

  # testbench, top module tb_surf_live_detector
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_surf_live_detector.sv
